/* hdl/fe_macros.svh */
`ifndef FE_MACROS_SVH
`define FE_MACROS_SVH

// Address and instruction widths
`define FE_VADDR_W 32
`define FE_INSTR_W 32

// Predictor table geometry, indexed from PC bit 2
`define FE_BTB_IDX_W 4
`define FE_BTB_TAG_W 6
`define FE_BHT_IDX_W 5

// Backend command opcodes
`define FE_OP_STATE_RESET 2'd0
`define FE_OP_REDIRECT    2'd1
`define FE_OP_BR_TAKEN    2'd2
`define FE_OP_BR_NTAKEN   2'd3

// RISC-V major opcodes seen by the scan
`define FE_RV_OP_BRANCH 7'b1100011
`define FE_RV_OP_JAL    7'b1101111

`endif

/* hdl/fe_pkg.sv */
package fe_pkg;

  // Conditional branch layout
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } rv_btype_s;

  // Jump and link layout
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_jtype_s;

  // One fetched word, seen either way
  // The opcode field lines up in both views
  typedef union packed {
    rv_btype_s b;
    rv_jtype_s j;
  } rv_instr_u;

endpackage

/* hdl/fe_train_if.sv */
`timescale 1ns/1ps
`include "fe_macros.svh"

interface fe_train_if;

  // Training pulse for one resolved branch
  logic                   w_v;
  logic                   taken;
  logic [`FE_VADDR_W-1:0] br_pc;
  logic [`FE_VADDR_W-1:0] target;

  modport ctrl (output w_v, taken, br_pc, target);

  // BTB only learns taken targets
  modport btb (input w_v, taken, br_pc, target);

  // Counters need the direction only
  modport bht (input w_v, taken, br_pc);

endinterface

/* hdl/fe_instr_scan.sv */
`timescale 1ns/1ps
`include "fe_macros.svh"

module fe_instr_scan (
  input  logic [`FE_INSTR_W-1:0] instr_i,
  output logic                   is_branch_o,
  output logic                   is_jal_o,
  output logic [`FE_VADDR_W-1:0] imm_o
);

  fe_pkg::rv_instr_u instr;

  assign instr       = instr_i;
  assign is_branch_o = (instr.b.opcode == `FE_RV_OP_BRANCH);
  assign is_jal_o    = (instr.j.opcode == `FE_RV_OP_JAL);

  // Reassemble the scattered offset bits, bit 0 is always zero
  always_comb begin
    if (is_jal_o) begin
      imm_o = {{(`FE_VADDR_W-20){instr.j.imm20}}, instr.j.imm19_12, instr.j.imm11,
               instr.j.imm10_1, 1'b0};
    end else if (is_branch_o) begin
      imm_o = {{(`FE_VADDR_W-12){instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5,
               instr.b.imm4_1, 1'b0};
    end else begin
      imm_o = '0;
    end
  end

endmodule

/* hdl/fe_btb.sv */
`timescale 1ns/1ps
`include "fe_macros.svh"

module fe_btb (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic [`FE_VADDR_W-1:0] r_pc_i,
  input  logic                   r_v_i,
  fe_train_if.btb                train,
  output logic [`FE_VADDR_W-1:0] tgt_o,
  output logic                   hit_o
);

  localparam int unsigned n_entries = 1 << `FE_BTB_IDX_W;

  logic [n_entries-1:0]    valid_r;
  logic [`FE_BTB_TAG_W-1:0] tag_r [n_entries];
  logic [`FE_VADDR_W-1:0]  tgt_r [n_entries];

  logic [`FE_BTB_IDX_W-1:0] r_idx, w_idx;
  logic [`FE_BTB_TAG_W-1:0] r_tag, w_tag;
  logic                     w_en;

  assign r_idx = r_pc_i[2 +: `FE_BTB_IDX_W];
  assign r_tag = r_pc_i[2 + `FE_BTB_IDX_W +: `FE_BTB_TAG_W];
  assign w_idx = train.br_pc[2 +: `FE_BTB_IDX_W];
  assign w_tag = train.br_pc[2 + `FE_BTB_IDX_W +: `FE_BTB_TAG_W];
  assign w_en  = train.w_v & train.taken;

  assign hit_o = r_v_i & valid_r[r_idx] & (tag_r[r_idx] == r_tag);
  assign tgt_o = tgt_r[r_idx];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r <= '0;
    end else if (w_en) begin
      valid_r[w_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_en) begin
      tag_r[w_idx] <= w_tag;
      tgt_r[w_idx] <= train.target;
    end
  end

endmodule

/* hdl/fe_bht.sv */
`timescale 1ns/1ps
`include "fe_macros.svh"

module fe_bht (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic [`FE_VADDR_W-1:0] r_pc_i,
  fe_train_if.bht                train,
  output logic                   taken_o
);

  localparam int unsigned n_ctrs = 1 << `FE_BHT_IDX_W;

  logic [1:0]               ctr_r [n_ctrs];
  logic [`FE_BHT_IDX_W-1:0] r_idx, w_idx;

  assign r_idx = r_pc_i[2 +: `FE_BHT_IDX_W];
  assign w_idx = train.br_pc[2 +: `FE_BHT_IDX_W];

  // Upper counter bit is the prediction
  assign taken_o = ctr_r[r_idx][1];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // Weakly not taken
      for (int i = 0; i < n_ctrs; i++) begin
        ctr_r[i] <= 2'b01;
      end
    end else if (train.w_v) begin
      if (train.taken && ctr_r[w_idx] != 2'b11) begin
        ctr_r[w_idx] <= ctr_r[w_idx] + 2'd1;
      end else if (!train.taken && ctr_r[w_idx] != 2'b00) begin
        ctr_r[w_idx] <= ctr_r[w_idx] - 2'd1;
      end
    end
  end

endmodule

/* hdl/fe_pc_ctrl.sv */
`timescale 1ns/1ps
`include "fe_macros.svh"

module fe_pc_ctrl (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   fe_cmd_v_i,
  input  logic [1:0]             fe_cmd_opcode_i,
  input  logic [`FE_VADDR_W-1:0] fe_cmd_vaddr_i,
  input  logic [`FE_VADDR_W-1:0] fe_cmd_br_pc_i,
  input  logic                   mem_cmd_yumi_i,
  input  logic                   mem_resp_v_i,
  input  logic                   mem_resp_miss_i,
  input  logic [`FE_INSTR_W-1:0] mem_resp_instr_i,
  input  logic                   fe_queue_ready_i,
  input  logic [`FE_VADDR_W-1:0] btb_tgt_i,
  input  logic                   btb_hit_i,
  input  logic                   bht_taken_i,
  input  logic                   is_branch_i,
  input  logic                   is_jal_i,
  input  logic [`FE_VADDR_W-1:0] imm_i,
  output logic [`FE_VADDR_W-1:0] btb_r_pc_o,
  output logic                   btb_r_v_o,
  output logic [`FE_VADDR_W-1:0] bht_r_pc_o,
  fe_train_if.ctrl               train,
  output logic                   mem_cmd_v_o,
  output logic [`FE_VADDR_W-1:0] mem_cmd_pc_o,
  output logic                   fe_queue_v_o,
  output logic [`FE_VADDR_W-1:0] fe_queue_pc_o,
  output logic [`FE_INSTR_W-1:0] fe_queue_instr_o,
  output logic                   fe_queue_pred_taken_o
);

  localparam logic [1:0] st_wait  = 2'd0;
  localparam logic [1:0] st_stall = 2'd1;
  localparam logic [1:0] st_run   = 2'd2;

  logic [1:0]             state_r, state_n;
  logic [`FE_VADDR_W-1:0] next_pc;
  logic [`FE_VADDR_W-1:0] resume_pc_r;

  // IF1 keeps its own BTB lookup, which predicts its successor
  logic                   if1_v_r, if1_pred_taken_r;
  logic [`FE_VADDR_W-1:0] if1_pc_r, if1_btb_tgt_r;
  logic                   if2_v_r, if2_pred_taken_r;
  logic [`FE_VADDR_W-1:0] if2_pc_r;

  logic is_wait, is_run;
  logic state_reset_v, cmd_fetch_v, br_cmd_v;
  logic fetch_v, flush, final_taken, ovr_taken, ovr_ntaken;

  assign is_wait = (state_r == st_wait);
  assign is_run  = (state_r == st_run);

  // Only a state reset wakes the frontend from wait
  assign state_reset_v = fe_cmd_v_i & (fe_cmd_opcode_i == `FE_OP_STATE_RESET);
  assign cmd_fetch_v   = state_reset_v | (fe_cmd_v_i & ~is_wait);
  assign br_cmd_v      = fe_cmd_v_i & ((fe_cmd_opcode_i == `FE_OP_BR_TAKEN)
                                     | (fe_cmd_opcode_i == `FE_OP_BR_NTAKEN));

  assign train.w_v    = br_cmd_v;
  assign train.taken  = (fe_cmd_opcode_i == `FE_OP_BR_TAKEN);
  assign train.br_pc  = fe_cmd_br_pc_i;
  assign train.target = fe_cmd_vaddr_i;

  // Missing response, miss, full queue or any command kills both stages
  assign flush = fe_cmd_v_i
               | (if2_v_r & (~mem_resp_v_i | mem_resp_miss_i | ~fe_queue_ready_i));

  assign fe_queue_v_o = if2_v_r & mem_resp_v_i & ~mem_resp_miss_i
                      & fe_queue_ready_i & ~fe_cmd_v_i;
  assign fe_queue_pc_o         = if2_pc_r;
  assign fe_queue_instr_o      = mem_resp_instr_i;
  assign fe_queue_pred_taken_o = final_taken;

  // Direction at IF2 against what IF1 was fetched with
  assign final_taken = is_jal_i | (is_branch_i & bht_taken_i);
  assign ovr_taken   = fe_queue_v_o & final_taken & ~if2_pred_taken_r;
  assign ovr_ntaken  = fe_queue_v_o & ~final_taken & if2_pred_taken_r;

  assign mem_cmd_v_o  = cmd_fetch_v | (~is_wait & fe_queue_ready_i & ~flush);
  assign mem_cmd_pc_o = next_pc;
  assign fetch_v      = mem_cmd_v_o & mem_cmd_yumi_i;

  assign btb_r_pc_o = next_pc;
  assign btb_r_v_o  = fetch_v;
  assign bht_r_pc_o = if2_pc_r;

  always_comb begin
    if (cmd_fetch_v) begin
      next_pc = fe_cmd_vaddr_i;
    end else if (!is_run) begin
      next_pc = resume_pc_r;
    end else if (ovr_taken) begin
      next_pc = if2_pc_r + imm_i;
    end else if (ovr_ntaken) begin
      next_pc = if2_pc_r + `FE_VADDR_W'd4;
    end else if (if1_v_r && if1_pred_taken_r) begin
      next_pc = if1_btb_tgt_r;
    end else if (if1_v_r) begin
      next_pc = if1_pc_r + `FE_VADDR_W'd4;
    end else begin
      // Last request was refused, ask again
      next_pc = if1_pc_r;
    end
  end

  always_comb begin
    state_n = state_r;
    case (state_r)
      st_wait: begin
        if (cmd_fetch_v) state_n = fetch_v ? st_run : st_stall;
      end
      st_stall: begin
        if (fetch_v) state_n = st_run;
      end
      st_run: begin
        if (cmd_fetch_v) begin
          state_n = fetch_v ? st_run : st_stall;
        end else if (flush) begin
          state_n = st_stall;
        end
      end
      default: state_n = st_wait;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= st_wait;
      if1_v_r <= 1'b0;
      if2_v_r <= 1'b0;
    end else begin
      state_r <= state_n;
      if1_v_r <= fetch_v;
      if2_v_r <= if1_v_r & ~flush & ~ovr_taken & ~ovr_ntaken;
    end
  end

  always_ff @(posedge clk_i) begin
    if1_pc_r         <= next_pc;
    if1_pred_taken_r <= btb_hit_i;
    if1_btb_tgt_r    <= btb_tgt_i;
    if2_pc_r         <= if1_pc_r;
    if2_pred_taken_r <= if1_pred_taken_r;
    // Restart point after a flush while running
    if (cmd_fetch_v) begin
      resume_pc_r <= fe_cmd_vaddr_i;
    end else if (is_run) begin
      resume_pc_r <= if2_pc_r;
    end
  end

endmodule

/* hdl/fe_pc_gen.sv */
`timescale 1ns/1ps
`include "fe_macros.svh"

module fe_pc_gen (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   fe_cmd_v_i,
  input  logic [1:0]             fe_cmd_opcode_i,
  input  logic [`FE_VADDR_W-1:0] fe_cmd_vaddr_i,
  input  logic [`FE_VADDR_W-1:0] fe_cmd_br_pc_i,
  output logic                   mem_cmd_v_o,
  output logic [`FE_VADDR_W-1:0] mem_cmd_pc_o,
  input  logic                   mem_cmd_yumi_i,
  input  logic                   mem_resp_v_i,
  input  logic [`FE_INSTR_W-1:0] mem_resp_instr_i,
  input  logic                   mem_resp_miss_i,
  output logic                   fe_queue_v_o,
  output logic [`FE_VADDR_W-1:0] fe_queue_pc_o,
  output logic [`FE_INSTR_W-1:0] fe_queue_instr_o,
  output logic                   fe_queue_pred_taken_o,
  input  logic                   fe_queue_ready_i
);

  logic [`FE_VADDR_W-1:0] btb_r_pc;
  logic                   btb_r_v;
  logic [`FE_VADDR_W-1:0] btb_tgt;
  logic                   btb_hit;
  logic [`FE_VADDR_W-1:0] bht_r_pc;
  logic                   bht_taken;
  logic                   is_branch;
  logic                   is_jal;
  logic [`FE_VADDR_W-1:0] imm;

  fe_train_if train_if ();

  fe_pc_ctrl ctrl_i (
    .clk_i(clk_i), .reset_i(reset_i),
    .fe_cmd_v_i(fe_cmd_v_i), .fe_cmd_opcode_i(fe_cmd_opcode_i),
    .fe_cmd_vaddr_i(fe_cmd_vaddr_i), .fe_cmd_br_pc_i(fe_cmd_br_pc_i),
    .mem_cmd_yumi_i(mem_cmd_yumi_i), .mem_resp_v_i(mem_resp_v_i),
    .mem_resp_miss_i(mem_resp_miss_i), .mem_resp_instr_i(mem_resp_instr_i),
    .fe_queue_ready_i(fe_queue_ready_i),
    .btb_tgt_i(btb_tgt), .btb_hit_i(btb_hit), .bht_taken_i(bht_taken),
    .is_branch_i(is_branch), .is_jal_i(is_jal), .imm_i(imm),
    .btb_r_pc_o(btb_r_pc), .btb_r_v_o(btb_r_v), .bht_r_pc_o(bht_r_pc),
    .train(train_if.ctrl),
    .mem_cmd_v_o(mem_cmd_v_o), .mem_cmd_pc_o(mem_cmd_pc_o),
    .fe_queue_v_o(fe_queue_v_o), .fe_queue_pc_o(fe_queue_pc_o),
    .fe_queue_instr_o(fe_queue_instr_o), .fe_queue_pred_taken_o(fe_queue_pred_taken_o)
  );

  fe_btb btb_i (
    .clk_i(clk_i), .reset_i(reset_i),
    .r_pc_i(btb_r_pc), .r_v_i(btb_r_v), .train(train_if.btb),
    .tgt_o(btb_tgt), .hit_o(btb_hit)
  );

  fe_bht bht_i (
    .clk_i(clk_i), .reset_i(reset_i),
    .r_pc_i(bht_r_pc), .train(train_if.bht),
    .taken_o(bht_taken)
  );

  fe_instr_scan scan_i (
    .instr_i(mem_resp_instr_i),
    .is_branch_o(is_branch), .is_jal_o(is_jal), .imm_o(imm)
  );

endmodule

/* bench/fe_pc_gen_chk.sv */
`timescale 1ns/1ps
`include "fe_macros.svh"

module fe_pc_gen_chk (
  input logic       clk_i,
  input logic       reset_i,
  input logic       fe_cmd_v_i,
  input logic [1:0] fe_cmd_opcode_i,
  input logic       mem_cmd_v_o,
  input logic       mem_resp_v_i,
  input logic       fe_queue_v_o,
  input logic       fe_queue_ready_i
);

  int unsigned err_cnt = 0;
  logic        started_r;
  logic        state_reset;

  assign state_reset = fe_cmd_v_i && (fe_cmd_opcode_i == `FE_OP_STATE_RESET);

  // Set by the first state reset after reset_i
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      started_r <= 1'b0;
    end else if (state_reset) begin
      started_r <= 1'b1;
    end
  end

  queue_needs_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    fe_queue_v_o |-> fe_queue_ready_i && mem_resp_v_i)
  else begin
    $error("queue entry without ready queue or memory response");
    err_cnt++;
  end

  no_fetch_before_start: assert property (@(posedge clk_i) disable iff (reset_i)
    !started_r && !state_reset |-> !mem_cmd_v_o)
  else begin
    $error("fetch request before the first state reset");
    err_cnt++;
  end

  no_queue_on_cmd: assert property (@(posedge clk_i) disable iff (reset_i)
    fe_cmd_v_i |-> !fe_queue_v_o)
  else begin
    $error("queue entry in a command cycle");
    err_cnt++;
  end

endmodule

bind fe_pc_gen fe_pc_gen_chk chk_i (.*);

/* bench/fe_pc_gen_tb.sv */
`timescale 1ns/1ps
`include "fe_macros.svh"

module fe_pc_gen_tb;

  localparam int test_cycles    = 6000;
  localparam int timeout_cycles = 3 * test_cycles + 2000;

  logic                   clk_i, reset_i, fe_cmd_v_i;
  logic [1:0]             fe_cmd_opcode_i;
  logic [`FE_VADDR_W-1:0] fe_cmd_vaddr_i, fe_cmd_br_pc_i, mem_cmd_pc_o, fe_queue_pc_o;
  logic                   mem_cmd_v_o, mem_cmd_yumi_i, mem_resp_v_i, mem_resp_miss_i;
  logic [`FE_INSTR_W-1:0] mem_resp_instr_i, fe_queue_instr_o;
  logic                   fe_queue_v_o, fe_queue_pred_taken_o, fe_queue_ready_i;

  // BHT mirror, expected stream and memory pipeline
  logic [1:0]             bht_m [1 << `FE_BHT_IDX_W];
  logic [`FE_VADDR_W-1:0] exp_pc, s1_pc, s2_pc, q_pc;
  logic                   started, s1_v, s2_v, q_seen, q_pred;
  int                     cycle_cnt = 0, n_entries = 0;
  int                     pc_errs = 0, instr_errs = 0, bit_errs = 0, other_errs = 0, total;

  fe_pc_gen dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Timeout: test still running after %0d cycles", cycle_cnt);
      $display("** FAIL **");
      $finish;
    end
  end

  // Offsets of 8 to 256 bytes that point backward in the upper 2 KB
  function automatic logic [`FE_VADDR_W-1:0] word_offset(input logic [`FE_VADDR_W-1:0] pc);
    logic [`FE_VADDR_W-1:0] mag;
    mag = ({27'd0, pc[8:4] ^ pc[11:7]} + 32'd1) << 3;
    return pc[11] ? -mag : mag;
  endfunction

  function automatic logic is_branch_pc(input logic [`FE_VADDR_W-1:0] pc);
    return (pc[4:2] == 3'd2) || (pc[4:2] == 3'd5);
  endfunction

  // Slots 2 and 5 of each 8-word group hold branches and slot 7 a JAL
  function automatic fe_pkg::rv_instr_u mem_word(input logic [`FE_VADDR_W-1:0] pc);
    fe_pkg::rv_instr_u w;
    logic [`FE_VADDR_W-1:0] off;
    off = word_offset(pc);
    w = {pc[11:2], pc[9:0], 5'd0, 7'b0010011};
    if (is_branch_pc(pc)) begin
      w.b.opcode  = `FE_RV_OP_BRANCH;
      w.b.imm12   = off[12];
      w.b.imm11   = off[11];
      w.b.imm10_5 = off[10:5];
      w.b.imm4_1  = off[4:1];
    end else if (pc[4:2] == 3'd7) begin
      w.j.opcode   = `FE_RV_OP_JAL;
      w.j.imm20    = off[20];
      w.j.imm19_12 = off[19:12];
      w.j.imm11    = off[11];
      w.j.imm10_1  = off[10:1];
    end
    return w;
  endfunction

  function automatic logic exp_taken(input logic [`FE_VADDR_W-1:0] pc);
    return (pc[4:2] == 3'd7) || (is_branch_pc(pc) && bht_m[pc[2 +: `FE_BHT_IDX_W]][1]);
  endfunction

  task automatic check_pc(input string name, input logic [`FE_VADDR_W-1:0] got, exp);
    if (got !== exp) begin
      pc_errs++;
      $display("** Error: %s = 0x%h, expected 0x%h (cycle %0d)", name, got, exp, cycle_cnt);
    end
  endtask

  task automatic check_instr(input string name, input fe_pkg::rv_instr_u got, exp);
    if (got !== exp) begin
      instr_errs++;
      $display("** Error: %s = 0x%h, expected 0x%h (cycle %0d)", name, got, exp, cycle_cnt);
    end
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    if (got !== exp) begin
      bit_errs++;
      $display("** Error: %s = 0x%h, expected 0x%h (cycle %0d)", name, got, exp, cycle_cnt);
    end
  endtask

  // Drive after the edge and sample late in the cycle
  task automatic run_cycle(input logic cmd_v, input logic [1:0] op,
                           input logic [`FE_VADDR_W-1:0] vaddr, br_pc);
    logic [`FE_BHT_IDX_W-1:0] idx;
    @(posedge clk_i);
    #1;
    fe_cmd_v_i       = cmd_v;
    fe_cmd_opcode_i  = op;
    fe_cmd_vaddr_i   = vaddr;
    fe_cmd_br_pc_i   = br_pc;
    mem_cmd_yumi_i   = ($urandom % 4) != 0;
    fe_queue_ready_i = ($urandom % 6) != 0;
    mem_resp_v_i     = s2_v;
    mem_resp_miss_i  = s2_v && (($urandom % 8) == 0);
    if (s2_v) begin
      mem_resp_instr_i = mem_word(s2_pc);
    end else begin
      mem_resp_instr_i = $urandom;
    end
    #5;
    if (!started) begin
      check_bit("mem_cmd_v_o", mem_cmd_v_o, cmd_v && (op == `FE_OP_STATE_RESET));
      check_bit("fe_queue_v_o", fe_queue_v_o, 1'b0);
    end
    if (cmd_v) begin
      check_bit("fe_queue_v_o", fe_queue_v_o, 1'b0);
    end
    q_seen = fe_queue_v_o;
    q_pc   = fe_queue_pc_o;
    q_pred = fe_queue_pred_taken_o;
    if (fe_queue_v_o) begin
      n_entries++;
      check_pc("fe_queue_pc_o", fe_queue_pc_o, exp_pc);
      check_instr("fe_queue_instr_o", fe_queue_instr_o, mem_word(exp_pc));
      check_bit("fe_queue_pred_taken_o", fe_queue_pred_taken_o, exp_taken(exp_pc));
      // Successor along the predicted direction
      exp_pc = exp_taken(exp_pc) ? exp_pc + word_offset(exp_pc) : exp_pc + 32'd4;
    end
    if (cmd_v && (started || op == `FE_OP_STATE_RESET)) begin
      check_bit("mem_cmd_v_o", mem_cmd_v_o, 1'b1);
      check_pc("mem_cmd_pc_o", mem_cmd_pc_o, vaddr);
      started = 1'b1;
      exp_pc  = vaddr;
    end
    idx = br_pc[2 +: `FE_BHT_IDX_W];
    if (cmd_v && op == `FE_OP_BR_TAKEN && bht_m[idx] != 2'b11) begin
      bht_m[idx] = bht_m[idx] + 2'd1;
    end else if (cmd_v && op == `FE_OP_BR_NTAKEN && bht_m[idx] != 2'b00) begin
      bht_m[idx] = bht_m[idx] - 2'd1;
    end
    s2_v  = s1_v;
    s2_pc = s1_pc;
    s1_v  = mem_cmd_v_o && mem_cmd_yumi_i;
    s1_pc = mem_cmd_pc_o;
  endtask

  task automatic idle_cycle();
    run_cycle(1'b0, 2'd0, 32'd0, 32'd0);
  endtask

  // Resolution redirects to the real successor of the branch
  task automatic resolve_branch(input logic [`FE_VADDR_W-1:0] pc, input logic taken);
    if (taken) begin
      run_cycle(1'b1, `FE_OP_BR_TAKEN, pc + word_offset(pc), pc);
    end else begin
      run_cycle(1'b1, `FE_OP_BR_NTAKEN, pc + 32'd4, pc);
    end
  endtask

  task automatic expect_entry(input logic [`FE_VADDR_W-1:0] pc);
    int n;
    n = 0;
    q_seen = 1'b0;
    while (!q_seen && n < 200) begin
      idle_cycle();
      n++;
    end
    if (!q_seen) begin
      other_errs++;
      $display("No queue entry within 200 cycles (cycle %0d)", cycle_cnt);
    end
    check_pc("fe_queue_pc_o", q_pc, pc);
  endtask

  task automatic follow_branch(input logic [`FE_VADDR_W-1:0] pc, input logic dir);
    run_cycle(1'b1, `FE_OP_REDIRECT, pc, 32'd0);
    expect_entry(pc);
    check_bit("fe_queue_pred_taken_o", q_pred, dir);
    expect_entry(dir ? pc + word_offset(pc) : pc + 32'd4);
  endtask

  task automatic random_cycle();
    logic [`FE_VADDR_W-1:0] pc;
    int unsigned            sel;
    pc  = ($urandom % 1024) * 4;
    sel = $urandom % 48;
    if (sel == 0) begin
      run_cycle(1'b1, `FE_OP_REDIRECT, pc, 32'd0);
    end else if (sel == 1) begin
      run_cycle(1'b1, `FE_OP_STATE_RESET, pc, 32'd0);
    end else if (sel < 4) begin
      resolve_branch({pc[31:5], (($urandom % 2) != 0) ? 3'd5 : 3'd2, 2'b00},
                     ($urandom % 2) != 0);
    end else begin
      idle_cycle();
    end
  endtask

  initial begin
    void'($urandom(23256));
    reset_i          = 1'b1;
    fe_cmd_v_i       = 1'b0;
    fe_cmd_opcode_i  = 2'd0;
    fe_cmd_vaddr_i   = '0;
    fe_cmd_br_pc_i   = '0;
    mem_cmd_yumi_i   = 1'b0;
    mem_resp_v_i     = 1'b0;
    mem_resp_instr_i = '0;
    mem_resp_miss_i  = 1'b0;
    fe_queue_ready_i = 1'b0;
    started          = 1'b0;
    s1_v             = 1'b0;
    s2_v             = 1'b0;
    s1_pc            = '0;
    s2_pc            = '0;
    exp_pc           = '0;
    for (int i = 0; i < (1 << `FE_BHT_IDX_W); i++) begin
      bht_m[i] = 2'b01;
    end
    repeat (2) @(posedge clk_i);
    #1 reset_i = 1'b0;

    // Wait state ignores a plain redirect
    repeat (6) idle_cycle();
    run_cycle(1'b1, `FE_OP_REDIRECT, 32'h200, 32'd0);
    repeat (6) idle_cycle();
    run_cycle(1'b1, `FE_OP_STATE_RESET, 32'h100, 32'd0);
    expect_entry(32'h100);
    repeat (test_cycles - 800) random_cycle();

    // Forward branch trained taken and then back to not taken
    resolve_branch(32'h348, 1'b1);
    resolve_branch(32'h348, 1'b1);
    follow_branch(32'h348, 1'b1);
    resolve_branch(32'h348, 1'b0);
    resolve_branch(32'h348, 1'b0);
    follow_branch(32'h348, 1'b0);

    // Redirect in a running stream
    repeat (30) idle_cycle();
    run_cycle(1'b1, `FE_OP_REDIRECT, 32'h7a0, 32'd0);
    expect_entry(32'h7a0);
    repeat (50) idle_cycle();

    if (n_entries < 200) begin
      other_errs++;
      $display("Too few queue entries: %0d", n_entries);
    end
    total = pc_errs + instr_errs + bit_errs + other_errs + int'(dut_i.chk_i.err_cnt);
    $display("Entries %0d, errors: pc %0d, instr %0d, bit %0d, other %0d, assert %0d",
             n_entries, pc_errs, instr_errs, bit_errs, other_errs, dut_i.chk_i.err_cnt);
    if (total == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+hdl
hdl/fe_pkg.sv
hdl/fe_train_if.sv
hdl/fe_instr_scan.sv
hdl/fe_btb.sv
hdl/fe_bht.sv
hdl/fe_pc_ctrl.sv
hdl/fe_pc_gen.sv
bench/fe_pc_gen_chk.sv
bench/fe_pc_gen_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the fetch PC generator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
  -f filelist.f --top-module fe_pc_gen_tb

# The run passes only if the pass message shows up
./obj_dir/Vfe_pc_gen_tb | tee /dev/stderr | grep -qF '** PASS **'
echo "Simulation passed"
